// File: logic/system_pkg.sv
package system_pkg;

  // Bus widths
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned DataWidth  = 32;
  localparam int unsigned StrbWidth  = DataWidth / 8;
  localparam int unsigned WordOffset = $clog2(StrbWidth); // Byte address to word index shift
  localparam int unsigned NumCores   = 4;

  // L2 data memory, 1 KiB
  localparam int unsigned          L2NumWords  = 256;
  localparam int unsigned          L2AddrWidth = $clog2(L2NumWords);
  localparam logic [AddrWidth-1:0] L2BaseAddr  = 32'h8000_0000;
  localparam logic [AddrWidth-1:0] L2Size      = L2NumWords * StrbWidth;

  // Boot memory
  localparam int unsigned          RomNumWords  = 64;
  localparam int unsigned          RomAddrWidth = $clog2(RomNumWords);
  localparam logic [AddrWidth-1:0] RomBaseAddr  = 32'hA000_0000;
  localparam logic [AddrWidth-1:0] RomSize      = RomNumWords * StrbWidth;
  localparam logic [DataWidth-1:0] RomSignature = 32'hB007_0000;

  // Control register window
  localparam int unsigned          CtrlOffsetWidth = 8;
  localparam logic [AddrWidth-1:0] CtrlBaseAddr    = 32'h4000_0000;
  localparam logic [AddrWidth-1:0] CtrlSize        = 32'h0001_0000;

  // TCDM layout as seen by the cores
  localparam logic [AddrWidth-1:0] TcdmBaseAddr = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] TcdmSize     = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] TcdmEndAddr  = TcdmBaseAddr + TcdmSize - 1;

  typedef enum logic [1:0] {TGT_CTRL, TGT_L2, TGT_ROM, TGT_NONE} target_e;

  typedef enum logic [1:0] {ST_IDLE, ST_READ_WAIT, ST_READ_RESP, ST_WRITE_RESP} router_state_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic [CtrlOffsetWidth-1:0] {
    REG_EOC        = 8'h00,
    REG_WAKE_UP    = 8'h04,
    REG_TCDM_START = 8'h08,
    REG_TCDM_END   = 8'h0C,
    REG_NUM_CORES  = 8'h10
  } ctrl_reg_e;

endpackage : system_pkg

// File: logic/l2_mem.sv
`timescale 1ns/1ps

module l2_mem
  import system_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [L2AddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0]   wdata_i,
  input  logic [StrbWidth-1:0]   strb_i,
  output logic [DataWidth-1:0]   rdata_o
);

  logic [DataWidth-1:0] mem_q [L2NumWords];

  // Single port, byte-masked writes
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (strb_i[b]) begin
          mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Registered read port
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule : l2_mem

// File: logic/bootrom.sv
`timescale 1ns/1ps

module bootrom
  import system_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    req_i,
  input  logic [RomAddrWidth-1:0] addr_i,
  output logic [DataWidth-1:0]    rdata_o
);

  logic [DataWidth-1:0] rom [RomNumWords];

  // Each word carries the signature tagged with its own index
  initial begin
    for (int k = 0; k < RomNumWords; k++) begin
      rom[k] = RomSignature ^ DataWidth'(k);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rom[addr_i];
    end
  end

endmodule : bootrom

// File: logic/ctrl_registers.sv
`timescale 1ns/1ps

module ctrl_registers
  import system_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [CtrlOffsetWidth-1:0] addr_i,
  input  logic [DataWidth-1:0]       wdata_i,
  output logic [DataWidth-1:0]       rdata_o,
  output logic [NumCores-1:0]        wake_up_o,
  output logic                       eoc_valid_o
);

  logic [DataWidth-1:0] eoc_q;
  logic [DataWidth-1:0] rd_value;
  logic                 wr_en;
  logic                 rd_en;

  assign wr_en = req_i & we_i;
  assign rd_en = req_i & ~we_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      eoc_q       <= '0;
      eoc_valid_o <= 1'b0;
      wake_up_o   <= '0;
    end else begin
      wake_up_o <= '0;   // Wake-up is a single-cycle pulse
      if (wr_en && addr_i == REG_EOC) begin
        eoc_q       <= wdata_i;
        eoc_valid_o <= 1'b1;   // Sticky until reset
      end
      if (wr_en && addr_i == REG_WAKE_UP) begin
        wake_up_o <= wdata_i[NumCores-1:0];
      end
    end
  end

  // Read mux, TCDM layout and core count are fixed
  always_comb begin
    case (addr_i)
      REG_EOC:        rd_value = eoc_q;
      REG_WAKE_UP:    rd_value = '0;
      REG_TCDM_START: rd_value = TcdmBaseAddr;
      REG_TCDM_END:   rd_value = TcdmEndAddr;
      REG_NUM_CORES:  rd_value = DataWidth'(NumCores);
      default:        rd_value = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_o <= rd_value;
    end
  end

  // Only one host write at a time, so pulses never merge
  a_wake_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wake_up_o != '0 |=> wake_up_o == '0)
    else $error("Wake-up held for more than one cycle");

endmodule : ctrl_registers

// File: logic/axi_lite_router.sv
`timescale 1ns/1ps

module axi_lite_router
  import system_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // AXI4-Lite slave port
  input  logic [AddrWidth-1:0] s_araddr_i,
  input  logic                 s_arvalid_i,
  output logic                 s_arready_o,
  output logic [DataWidth-1:0] s_rdata_o,
  output logic [1:0]           s_rresp_o,
  output logic                 s_rvalid_o,
  input  logic                 s_rready_i,
  input  logic [AddrWidth-1:0] s_awaddr_i,
  input  logic                 s_awvalid_i,
  output logic                 s_awready_o,
  input  logic [DataWidth-1:0] s_wdata_i,
  input  logic [StrbWidth-1:0] s_wstrb_i,
  input  logic                 s_wvalid_i,
  output logic                 s_wready_o,
  output logic [1:0]           s_bresp_o,
  output logic                 s_bvalid_o,
  input  logic                 s_bready_i,
  // Target side
  output logic [AddrWidth-1:0] tgt_addr_o,
  output logic                 tgt_we_o,
  output logic [DataWidth-1:0] tgt_wdata_o,
  output logic [StrbWidth-1:0] tgt_strb_o,
  output logic                 l2_req_o,
  output logic                 rom_req_o,
  output logic                 reg_req_o,
  input  logic [DataWidth-1:0] l2_rdata_i,
  input  logic [DataWidth-1:0] rom_rdata_i,
  input  logic [DataWidth-1:0] reg_rdata_i,
  output logic                 busy_o
);

  router_state_e        state_q;
  target_e              tgt_q;
  target_e              dec_tgt;
  axi_resp_e            dec_resp;
  axi_resp_e            resp_q;
  logic                 issue_q;   // Target request cycle
  logic [AddrWidth-1:0] addr_q;
  logic                 we_q;
  logic [DataWidth-1:0] wdata_q;
  logic [StrbWidth-1:0] strb_q;
  logic [DataWidth-1:0] rdata_q;
  logic [DataWidth-1:0] rdata_sel;
  logic [AddrWidth-1:0] dec_addr;
  logic                 wr_pending;
  logic                 wr_accept;
  logic                 rd_accept;

  function automatic target_e decode(input logic [AddrWidth-1:0] addr);
    if (addr >= CtrlBaseAddr && addr < CtrlBaseAddr + CtrlSize)
      return TGT_CTRL;
    if (addr >= L2BaseAddr && addr < L2BaseAddr + L2Size)
      return TGT_L2;
    if (addr >= RomBaseAddr && addr < RomBaseAddr + RomSize)
      return TGT_ROM;
    return TGT_NONE;
  endfunction

  // Writes need AW and W together and win over a waiting read
  assign wr_pending  = s_awvalid_i & s_wvalid_i;
  assign wr_accept   = (state_q == ST_IDLE) & wr_pending;
  assign rd_accept   = (state_q == ST_IDLE) & s_arvalid_i & ~wr_pending;
  assign s_awready_o = wr_accept;
  assign s_wready_o  = wr_accept;
  assign s_arready_o = rd_accept;

  assign dec_addr = wr_pending ? s_awaddr_i : s_araddr_i;
  assign dec_tgt  = decode(dec_addr);

  always_comb begin
    if (dec_tgt == TGT_NONE) begin
      dec_resp = RESP_DECERR;
    end else if (wr_pending && dec_tgt == TGT_ROM) begin
      dec_resp = RESP_SLVERR;   // ROM is read only
    end else begin
      dec_resp = RESP_OKAY;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      tgt_q   <= TGT_NONE;
      issue_q <= 1'b0;
    end else begin
      issue_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (wr_accept) begin
            state_q <= ST_WRITE_RESP;
            tgt_q   <= dec_tgt;
            issue_q <= (dec_tgt != TGT_ROM);
          end else if (rd_accept) begin
            state_q <= ST_READ_WAIT;
            tgt_q   <= dec_tgt;
            issue_q <= 1'b1;
          end
        end
        ST_READ_WAIT: begin
          if (!issue_q) begin
            state_q <= ST_READ_RESP;   // Target data captured this edge
          end
        end
        ST_READ_RESP: begin
          if (s_rready_i) begin
            state_q <= ST_IDLE;
          end
        end
        ST_WRITE_RESP: begin
          if (s_bready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request payload and response
  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      addr_q  <= s_awaddr_i;
      we_q    <= 1'b1;
      wdata_q <= s_wdata_i;
      strb_q  <= s_wstrb_i;
      resp_q  <= dec_resp;
    end else if (rd_accept) begin
      addr_q <= s_araddr_i;
      we_q   <= 1'b0;
      resp_q <= dec_resp;
    end
    if (state_q == ST_READ_WAIT && !issue_q) begin
      rdata_q <= rdata_sel;
    end
  end

  always_comb begin
    case (tgt_q)
      TGT_CTRL: rdata_sel = reg_rdata_i;
      TGT_L2:   rdata_sel = l2_rdata_i;
      TGT_ROM:  rdata_sel = rom_rdata_i;
      default:  rdata_sel = '0;   // Unmapped reads return zero
    endcase
  end

  assign l2_req_o  = issue_q & (tgt_q == TGT_L2);
  assign rom_req_o = issue_q & (tgt_q == TGT_ROM);
  assign reg_req_o = issue_q & (tgt_q == TGT_CTRL);

  assign tgt_addr_o  = addr_q;
  assign tgt_we_o    = we_q;
  assign tgt_wdata_o = wdata_q;
  assign tgt_strb_o  = strb_q;

  assign s_rvalid_o = (state_q == ST_READ_RESP);
  assign s_bvalid_o = (state_q == ST_WRITE_RESP);
  assign s_rdata_o  = rdata_q;
  assign s_rresp_o  = resp_q;
  assign s_bresp_o  = resp_q;
  assign busy_o     = (state_q != ST_IDLE);

  a_single_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(s_rvalid_o && s_bvalid_o))
    else $error("R and B channels valid together");

  a_rdata_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o))
    else $error("Read response changed under back-pressure");

  a_one_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({l2_req_o, rom_req_o, reg_req_o}))
    else $error("More than one target request");

endmodule : axi_lite_router

// File: logic/cluster_system.sv
`timescale 1ns/1ps

module cluster_system
  import system_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [AddrWidth-1:0] s_araddr_i,
  input  logic                 s_arvalid_i,
  output logic                 s_arready_o,
  output logic [DataWidth-1:0] s_rdata_o,
  output logic [1:0]           s_rresp_o,
  output logic                 s_rvalid_o,
  input  logic                 s_rready_i,
  input  logic [AddrWidth-1:0] s_awaddr_i,
  input  logic                 s_awvalid_i,
  output logic                 s_awready_o,
  input  logic [DataWidth-1:0] s_wdata_i,
  input  logic [StrbWidth-1:0] s_wstrb_i,
  input  logic                 s_wvalid_i,
  output logic                 s_wready_o,
  output logic [1:0]           s_bresp_o,
  output logic                 s_bvalid_o,
  input  logic                 s_bready_i,
  output logic                 busy_o,
  output logic [NumCores-1:0]  wake_up_o,
  output logic                 eoc_valid_o
);

  logic [AddrWidth-1:0] tgt_addr;
  logic                 tgt_we;
  logic [DataWidth-1:0] tgt_wdata;
  logic [StrbWidth-1:0] tgt_strb;
  logic                 l2_req;
  logic                 rom_req;
  logic                 reg_req;
  logic [DataWidth-1:0] l2_rdata;
  logic [DataWidth-1:0] rom_rdata;
  logic [DataWidth-1:0] reg_rdata;

  axi_lite_router i_router (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .s_araddr_i (s_araddr_i ),
    .s_arvalid_i(s_arvalid_i),
    .s_arready_o(s_arready_o),
    .s_rdata_o  (s_rdata_o  ),
    .s_rresp_o  (s_rresp_o  ),
    .s_rvalid_o (s_rvalid_o ),
    .s_rready_i (s_rready_i ),
    .s_awaddr_i (s_awaddr_i ),
    .s_awvalid_i(s_awvalid_i),
    .s_awready_o(s_awready_o),
    .s_wdata_i  (s_wdata_i  ),
    .s_wstrb_i  (s_wstrb_i  ),
    .s_wvalid_i (s_wvalid_i ),
    .s_wready_o (s_wready_o ),
    .s_bresp_o  (s_bresp_o  ),
    .s_bvalid_o (s_bvalid_o ),
    .s_bready_i (s_bready_i ),
    .tgt_addr_o (tgt_addr   ),
    .tgt_we_o   (tgt_we     ),
    .tgt_wdata_o(tgt_wdata  ),
    .tgt_strb_o (tgt_strb   ),
    .l2_req_o   (l2_req     ),
    .rom_req_o  (rom_req    ),
    .reg_req_o  (reg_req    ),
    .l2_rdata_i (l2_rdata   ),
    .rom_rdata_i(rom_rdata  ),
    .reg_rdata_i(reg_rdata  ),
    .busy_o     (busy_o     )
  );

  // Word index inside the L2 window
  l2_mem i_l2_mem (
    .clk_i  (clk_i                                     ),
    .req_i  (l2_req                                    ),
    .we_i   (tgt_we                                    ),
    .addr_i (tgt_addr[WordOffset +: L2AddrWidth]       ),
    .wdata_i(tgt_wdata                                 ),
    .strb_i (tgt_strb                                  ),
    .rdata_o(l2_rdata                                  )
  );

  bootrom i_bootrom (
    .clk_i  (clk_i                                ),
    .req_i  (rom_req                              ),
    .addr_i (tgt_addr[WordOffset +: RomAddrWidth] ),
    .rdata_o(rom_rdata                            )
  );

  ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i                        ),
    .rst_n_i    (rst_n_i                      ),
    .req_i      (reg_req                      ),
    .we_i       (tgt_we                       ),
    .addr_i     (tgt_addr[CtrlOffsetWidth-1:0]), // Byte offset
    .wdata_i    (tgt_wdata                    ),
    .rdata_o    (reg_rdata                    ),
    .wake_up_o  (wake_up_o                    ),
    .eoc_valid_o(eoc_valid_o                  )
  );

endmodule : cluster_system

// File: tb/tb_cluster_system.sv
`timescale 1ns/1ps

module tb_cluster_system
  import system_pkg::*;
();

  localparam int unsigned MaxCycles = 6000;  // About 300 transactions of up to 15 cycles
  localparam logic [AddrWidth-1:0] BadAddr = 32'h2000_0000;  // Outside every window

  logic                 clk_i;
  logic                 rst_n_i;
  logic [AddrWidth-1:0] s_araddr_i;
  logic                 s_arvalid_i;
  logic                 s_arready_o;
  logic [DataWidth-1:0] s_rdata_o;
  logic [1:0]           s_rresp_o;
  logic                 s_rvalid_o;
  logic                 s_rready_i;
  logic [AddrWidth-1:0] s_awaddr_i;
  logic                 s_awvalid_i;
  logic                 s_awready_o;
  logic [DataWidth-1:0] s_wdata_i;
  logic [StrbWidth-1:0] s_wstrb_i;
  logic                 s_wvalid_i;
  logic                 s_wready_o;
  logic [1:0]           s_bresp_o;
  logic                 s_bvalid_o;
  logic                 s_bready_i;
  logic                 busy_o;
  logic [NumCores-1:0]  wake_up_o;
  logic                 eoc_valid_o;

  logic [DataWidth-1:0] l2_model [L2NumWords];  // Expected L2 contents
  int unsigned          l2_used [$];            // Word indices that hold known data
  logic [DataWidth-1:0] exp_rdata;
  logic [1:0]           exp_rresp;
  logic [1:0]           exp_bresp;
  logic [NumCores-1:0]  exp_wake;
  logic                 req_seen;
  int unsigned          cycle_cnt;
  logic                 ar_hs;
  logic                 wr_hs;
  logic                 wake_hs;
  logic                 eoc_hs;

  cluster_system cluster_system_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [AddrWidth-1:0] reg_addr(input ctrl_reg_e off);
    return CtrlBaseAddr | AddrWidth'(off);
  endfunction

  assign ar_hs   = s_arvalid_i & s_arready_o;
  assign wr_hs   = s_awvalid_i & s_awready_o & s_wvalid_i & s_wready_o;
  assign wake_hs = wr_hs & (s_awaddr_i == reg_addr(REG_WAKE_UP));
  assign eoc_hs  = wr_hs & (s_awaddr_i == reg_addr(REG_EOC));

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MaxCycles) begin
      $display("Timeout after %0d cycles, the DUT never finished the test sequence", MaxCycles);
      abort_run();
    end
  end

  a_reset_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !req_seen |-> !(s_arready_o || s_awready_o || s_wready_o || s_rvalid_o || s_bvalid_o ||
                    busy_o || eoc_valid_o) && wake_up_o == '0)
    else report_mismatch("output active before the first request");
  a_read_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(ar_hs, 3) |-> s_rvalid_o && !$past(s_rvalid_o) && !$past(s_rvalid_o, 2))
    else report_mismatch("rvalid not raised two cycles after AR transfer");
  a_write_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(wr_hs) |-> s_bvalid_o)
    else report_mismatch("bvalid not raised one cycle after write transfer");
  a_read_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_rvalid_o && s_rready_i |-> s_rdata_o == exp_rdata && s_rresp_o == exp_rresp)
    else report_mismatch($sformatf("read got %h/%0d, expected %h/%0d",
                                   s_rdata_o, s_rresp_o, exp_rdata, exp_rresp));
  a_write_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_bvalid_o && s_bready_i |-> s_bresp_o == exp_bresp)
    else report_mismatch($sformatf("bresp %0d, expected %0d", s_bresp_o, exp_bresp));
  a_read_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(s_rvalid_o && !s_rready_i) |-> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o))
    else report_mismatch("read response dropped or changed under back-pressure");
  a_write_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(s_bvalid_o && !s_bready_i) |-> s_bvalid_o && $stable(s_bresp_o))
    else report_mismatch("write response dropped or changed under back-pressure");
  a_busy_blocks: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_rvalid_o || s_bvalid_o |-> busy_o && !s_arready_o && !s_awready_o && !s_wready_o)
    else report_mismatch("new request accepted or busy low while a response is pending");
  a_wake_value: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(wake_hs, 2) |-> wake_up_o == exp_wake)
    else report_mismatch($sformatf("wake_up_o %b, expected %b", wake_up_o, exp_wake));
  a_wake_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wake_up_o != '0 |-> $past(wake_hs, 2))
    else report_mismatch("wake_up_o high outside its one-cycle pulse");
  a_eoc_set: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(eoc_hs, 2) |-> eoc_valid_o)
    else report_mismatch("eoc_valid_o not set after EOC write");

  // Back-pressure holds response ready low for 1 to 4 cycles
  // and offers the same request again while the response waits
  task automatic axi_read(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data,
                          input logic [1:0] resp, input bit bp);
    exp_rdata   = data;
    exp_rresp   = resp;
    req_seen    = 1'b1;
    s_araddr_i  = addr;
    s_arvalid_i = 1'b1;
    s_rready_i  = !bp;
    for (int n = int'(bp); n >= 0; n--) begin
      do @(negedge clk_i); while (!s_arready_o);
      @(posedge clk_i);
      #1 s_arvalid_i = (n > 0);  // Repeat stays valid behind the pending response
      do @(negedge clk_i); while (!s_rvalid_o);
      if (bp) begin
        repeat ($urandom_range(4, 1)) @(posedge clk_i);
        #1 s_rready_i = 1'b1;
      end
      @(posedge clk_i);
      #1 s_rready_i = !bp;
    end
  endtask

  task automatic axi_write(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data,
                           input logic [StrbWidth-1:0] strb, input logic [1:0] resp, input bit bp);
    exp_bresp   = resp;
    req_seen    = 1'b1;
    s_awaddr_i  = addr;
    s_wdata_i   = data;
    s_wstrb_i   = strb;
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
    s_bready_i  = !bp;
    for (int n = int'(bp); n >= 0; n--) begin
      do @(negedge clk_i); while (!s_awready_o);
      @(posedge clk_i);
      #1;
      s_awvalid_i = (n > 0);
      s_wvalid_i  = (n > 0);
      do @(negedge clk_i); while (!s_bvalid_o);
      if (bp) begin
        repeat ($urandom_range(4, 1)) @(posedge clk_i);
        #1 s_bready_i = 1'b1;
      end
      @(posedge clk_i);
      #1 s_bready_i = !bp;
    end
  endtask

  task automatic l2_write(input int unsigned idx, input logic [DataWidth-1:0] data,
                          input logic [StrbWidth-1:0] strb, input bit bp);
    for (int b = 0; b < StrbWidth; b++) begin
      if (strb[b]) l2_model[idx][8*b +: 8] = data[8*b +: 8];  // Byte merge
    end
    axi_write(L2BaseAddr + idx * StrbWidth, data, strb, RESP_OKAY, bp);
  endtask

  task automatic l2_read(input int unsigned idx, input bit bp);
    axi_read(L2BaseAddr + idx * StrbWidth, l2_model[idx], RESP_OKAY, bp);
  endtask

  task automatic rom_read(input int unsigned idx, input bit bp);
    axi_read(RomBaseAddr + idx * StrbWidth, RomSignature ^ idx, RESP_OKAY, bp);
  endtask

  initial begin
    int unsigned          idx;
    int unsigned          pick;
    logic [DataWidth-1:0] data;
    void'($urandom(32'heb97f228));
    cycle_cnt   = 0;
    req_seen    = 1'b0;
    exp_rdata   = '0;
    exp_rresp   = '0;
    exp_bresp   = '0;
    exp_wake    = '0;
    rst_n_i     = 1'b0;
    s_araddr_i  = '0;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b0;
    s_awaddr_i  = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = '0;
    s_wstrb_i   = '0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b0;
    repeat (10) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    repeat (5) @(posedge clk_i);  // Idle outputs checked by a_reset_quiet
    #1;

    // L2, full word first so every byte is known, then a random strobe
    for (int i = 0; i < 32; i++) begin
      idx = $urandom_range(L2NumWords - 1, 0);
      l2_used.push_back(idx);
      l2_write(idx, $urandom, '1, 1'b0);
      l2_write(idx, $urandom, StrbWidth'($urandom), 1'b0);
    end
    foreach (l2_used[i]) l2_read(l2_used[i], 1'b0);

    // Boot memory
    for (int i = 0; i < 16; i++) rom_read($urandom_range(RomNumWords - 1, 0), 1'b0);
    idx = $urandom_range(RomNumWords - 1, 0);
    axi_write(RomBaseAddr + idx * StrbWidth, 32'hDEAD_BEEF, '1, RESP_SLVERR, 1'b0);
    rom_read(idx, 1'b0);

    // Control registers
    axi_read(reg_addr(REG_TCDM_START), TcdmBaseAddr, RESP_OKAY, 1'b0);
    axi_read(reg_addr(REG_TCDM_END), TcdmBaseAddr + TcdmSize - 1, RESP_OKAY, 1'b0);
    axi_read(reg_addr(REG_NUM_CORES), NumCores, RESP_OKAY, 1'b0);
    data = $urandom;
    axi_write(reg_addr(REG_EOC), data, '1, RESP_OKAY, 1'b0);
    axi_read(reg_addr(REG_EOC), data, RESP_OKAY, 1'b0);
    for (int i = 0; i < 3; i++) begin
      data     = $urandom;
      data[0]  = 1'b1;  // Nonzero mask
      exp_wake = NumCores'(data);
      axi_write(reg_addr(REG_WAKE_UP), data, '1, RESP_OKAY, 1'b0);
      @(posedge clk_i);  // Pulse lands here, before the next mask
      #1;
    end
    axi_read(reg_addr(REG_WAKE_UP), '0, RESP_OKAY, 1'b0);
    axi_write(reg_addr(REG_TCDM_START), 32'h1234_5678, '1, RESP_OKAY, 1'b0);
    axi_read(reg_addr(REG_TCDM_START), TcdmBaseAddr, RESP_OKAY, 1'b0);
    axi_read(CtrlBaseAddr + 32'h20, '0, RESP_OKAY, 1'b0);  // Unknown offset

    // Unmapped window
    axi_read(BadAddr, '0, RESP_DECERR, 1'b0);
    axi_write(BadAddr, 32'hCAFE_F00D, '1, RESP_DECERR, 1'b0);

    // Mixed traffic with random response back-pressure
    for (int i = 0; i < 48; i++) begin
      pick = $urandom_range(2, 0);
      idx  = l2_used[$urandom_range(l2_used.size() - 1, 0)];
      case (pick)
        0:       l2_write(idx, $urandom, StrbWidth'($urandom), 1'b1);
        1:       l2_read(idx, 1'b1);
        default: rom_read($urandom_range(RomNumWords - 1, 0), 1'b1);
      endcase
    end
    foreach (l2_used[i]) l2_read(l2_used[i], 1'b1);

    repeat (4) @(posedge clk_i);
    $display("Test OK");
    $finish;
  end

endmodule : tb_cluster_system

// File: filelist.f
logic/system_pkg.sv
logic/l2_mem.sv
logic/bootrom.sv
logic/ctrl_registers.sv
logic/axi_lite_router.sv
logic/cluster_system.sv
tb/tb_cluster_system.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cluster system testbench with Verilator.
# The exit status is the simulator's, so a failing run returns nonzero.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f filelist.f \
  --top-module tb_cluster_system \
  -Mdir obj_dir -o sim_tb_cluster_system
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_tb_cluster_system
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

exit 0
